/* bridge_map_pkg.sv */
// --------------------------------------------------
// Address map and bus widths of the external slave
// bridge, shared by the RTL and the testbench
// --------------------------------------------------

package bridge_map_pkg;

  // External slave ports behind the bridge
  localparam int unsigned NumPorts = 4;

  // Request and response bus widths
  localparam int unsigned AddrWidth = 32;
  localparam int unsigned DataWidth = 32;
  localparam int unsigned IdWidth   = 4;

  // Port select sits just above the 4 KiB window of each port
  localparam int unsigned PortSelLsb  = 12;
  localparam int unsigned PortSelBits = 2;

  // Bits 31:14 of a mapped address, port p at 0x1000_0000 + p * 0x1000
  localparam logic [AddrWidth-1-PortSelLsb-PortSelBits:0] MapTag = 18'h04000;

  // Outstanding requests allowed per port
  localparam int unsigned MaxPending   = 4;
  localparam int unsigned PendCntWidth = $clog2(MaxPending + 1);

endpackage

/* bridge_txn_pkg.sv */
// --------------------------------------------------
// Opcode, response code and isolation state
// encodings of the external slave bridge
// --------------------------------------------------

package bridge_txn_pkg;

  typedef enum logic {
    OP_READ  = 1'b0,
    OP_WRITE = 1'b1
  } op_e;

  // Same values as the AXI BRESP/RRESP field
  typedef enum logic [1:0] {
    RESP_OKAY   = 2'b00,
    RESP_SLVERR = 2'b10,
    RESP_DECERR = 2'b11
  } resp_e;

  typedef enum logic [1:0] {
    ISO_RUN      = 2'b00,
    ISO_DRAIN    = 2'b01,
    ISO_ISOLATED = 2'b10
  } iso_state_e;

endpackage

/* ext_port_bridge.f */
bridge_map_pkg.sv
bridge_txn_pkg.sv
ext_port_router.sv
ext_port_isolate.sv
ext_rsp_arbiter.sv
ext_port_bridge.sv
ext_port_bridge_assertions.sv
ext_port_bridge_tb.sv

/* ext_port_bridge.sv */
// --------------------------------------------------
// External slave bridge: router, one isolation stage
// per slave port and the response arbiter
// --------------------------------------------------

`timescale 1ns/1ns

module ext_port_bridge
  import bridge_map_pkg::*;
  import bridge_txn_pkg::*;
(
  input  logic                               clk_i,
  input  logic                               rst_i,
  // Host request
  input  logic                               req_valid_i,
  input  op_e                                req_op_i,
  input  logic [IdWidth-1:0]                 req_id_i,
  input  logic [AddrWidth-1:0]               req_addr_i,
  input  logic [DataWidth-1:0]               req_wdata_i,
  output logic                               req_ready_o,
  // Host response
  output logic                               rsp_valid_o,
  output logic [IdWidth-1:0]                 rsp_id_o,
  output resp_e                              rsp_resp_o,
  output logic [DataWidth-1:0]               rsp_rdata_o,
  input  logic                               rsp_ready_i,
  // Slave requests, payload shared by all ports
  output logic [NumPorts-1:0]                slv_req_valid_o,
  output op_e                                slv_req_op_o,
  output logic [IdWidth-1:0]                 slv_req_id_o,
  output logic [AddrWidth-1:0]               slv_req_addr_o,
  output logic [DataWidth-1:0]               slv_req_wdata_o,
  input  logic [NumPorts-1:0]                slv_req_ready_i,
  // Slave responses
  input  logic [NumPorts-1:0]                slv_rsp_valid_i,
  input  logic [NumPorts-1:0][IdWidth-1:0]   slv_rsp_id_i,
  input  resp_e [NumPorts-1:0]               slv_rsp_resp_i,
  input  logic [NumPorts-1:0][DataWidth-1:0] slv_rsp_rdata_i,
  output logic [NumPorts-1:0]                slv_rsp_ready_o,
  // Isolation control
  input  logic [NumPorts-1:0]                slv_isolate_i,
  output logic [NumPorts-1:0]                slv_isolated_o
);

  logic [NumPorts-1:0]                port_req_valid;
  logic [NumPorts-1:0]                port_req_ready;
  logic [NumPorts-1:0]                port_rsp_valid;
  logic [NumPorts-1:0][IdWidth-1:0]   port_rsp_id;
  resp_e [NumPorts-1:0]               port_rsp_resp;
  logic [NumPorts-1:0][DataWidth-1:0] port_rsp_rdata;
  logic [NumPorts-1:0]                port_rsp_ready;
  logic                               dec_rsp_valid;
  logic [IdWidth-1:0]                 dec_rsp_id;
  logic                               dec_rsp_ready;

  assign slv_req_op_o    = req_op_i;
  assign slv_req_id_o    = req_id_i;
  assign slv_req_addr_o  = req_addr_i;
  assign slv_req_wdata_o = req_wdata_i;

  ext_port_router i_router (
    .clk_i            ( clk_i          ),
    .rst_i            ( rst_i          ),
    .req_valid_i      ( req_valid_i    ),
    .req_op_i         ( req_op_i       ),
    .req_id_i         ( req_id_i       ),
    .req_addr_i       ( req_addr_i     ),
    .req_wdata_i      ( req_wdata_i    ),
    .req_ready_o      ( req_ready_o    ),
    .port_req_valid_o ( port_req_valid ),
    .port_req_ready_i ( port_req_ready ),
    .dec_rsp_valid_o  ( dec_rsp_valid  ),
    .dec_rsp_id_o     ( dec_rsp_id     ),
    .dec_rsp_ready_i  ( dec_rsp_ready  )
  );

  for (genvar p = 0; p < NumPorts; p++) begin : gen_port_isolate
    ext_port_isolate i_port_isolate (
      .clk_i           ( clk_i              ),
      .rst_i           ( rst_i              ),
      .in_req_valid_i  ( port_req_valid[p]  ),
      .in_req_op_i     ( req_op_i           ),
      .in_req_id_i     ( req_id_i           ),
      .in_req_ready_o  ( port_req_ready[p]  ),
      .slv_req_valid_o ( slv_req_valid_o[p] ),
      .slv_req_ready_i ( slv_req_ready_i[p] ),
      .slv_rsp_valid_i ( slv_rsp_valid_i[p] ),
      .slv_rsp_id_i    ( slv_rsp_id_i[p]    ),
      .slv_rsp_resp_i  ( slv_rsp_resp_i[p]  ),
      .slv_rsp_rdata_i ( slv_rsp_rdata_i[p] ),
      .slv_rsp_ready_o ( slv_rsp_ready_o[p] ),
      .out_rsp_valid_o ( port_rsp_valid[p]  ),
      .out_rsp_id_o    ( port_rsp_id[p]     ),
      .out_rsp_resp_o  ( port_rsp_resp[p]   ),
      .out_rsp_rdata_o ( port_rsp_rdata[p]  ),
      .out_rsp_ready_i ( port_rsp_ready[p]  ),
      .isolate_i       ( slv_isolate_i[p]   ),
      .isolated_o      ( slv_isolated_o[p]  )
    );
  end

  ext_rsp_arbiter i_rsp_arbiter (
    .clk_i            ( clk_i          ),
    .rst_i            ( rst_i          ),
    .port_rsp_valid_i ( port_rsp_valid ),
    .port_rsp_id_i    ( port_rsp_id    ),
    .port_rsp_resp_i  ( port_rsp_resp  ),
    .port_rsp_rdata_i ( port_rsp_rdata ),
    .port_rsp_ready_o ( port_rsp_ready ),
    .dec_rsp_valid_i  ( dec_rsp_valid  ),
    .dec_rsp_id_i     ( dec_rsp_id     ),
    .dec_rsp_ready_o  ( dec_rsp_ready  ),
    .rsp_valid_o      ( rsp_valid_o    ),
    .rsp_id_o         ( rsp_id_o       ),
    .rsp_resp_o       ( rsp_resp_o     ),
    .rsp_rdata_o      ( rsp_rdata_o    ),
    .rsp_ready_i      ( rsp_ready_i    )
  );

endmodule

/* ext_port_bridge_assertions.sv */
// --------------------------------------------------
// Bound checks of the external slave bridge: routing,
// reset state, isolation and response back-pressure
// --------------------------------------------------

`timescale 1ns/1ns

module ext_port_bridge_assertions
  import bridge_map_pkg::*;
  import bridge_txn_pkg::*;
(
  input logic                 clk_i,
  input logic                 rst_i,
  input logic                 rsp_valid_i,
  input logic [IdWidth-1:0]   rsp_id_i,
  input resp_e                rsp_resp_i,
  input logic [DataWidth-1:0] rsp_rdata_i,
  input logic                 rsp_ready_i,
  input logic [NumPorts-1:0]  slv_req_valid_i,
  input logic [NumPorts-1:0]  slv_req_ready_i,
  input logic [AddrWidth-1:0] slv_req_addr_i,
  input logic [NumPorts-1:0]  slv_rsp_valid_i,
  input logic [NumPorts-1:0]  slv_rsp_ready_i,
  input logic [NumPorts-1:0]  slv_isolate_i,
  input logic [NumPorts-1:0]  slv_isolated_i
);

  int fail_cnt = 0;

  // Outstanding requests seen at each slave
  logic [NumPorts-1:0][PendCntWidth-1:0] pend_cnt;

  always_ff @(posedge clk_i) begin
    for (int p = 0; p < NumPorts; p++) begin
      if (rst_i) begin
        pend_cnt[p] <= '0;
      end else begin
        pend_cnt[p] <= pend_cnt[p]
                       + PendCntWidth'(slv_req_valid_i[p] && slv_req_ready_i[p])
                       - PendCntWidth'(slv_rsp_valid_i[p] && slv_rsp_ready_i[p]);
      end
    end
  end

  reset_idle: assert property (@(posedge clk_i)
    rst_i |=> !rsp_valid_i && (slv_req_valid_i == '0) && (slv_isolated_i == '0))
    else begin
      fail_cnt++;
      $error("bridge outputs not idle after reset");
    end

  one_port_only: assert property (@(posedge clk_i) disable iff (rst_i)
    $onehot0(slv_req_valid_i))
    else begin
      fail_cnt++;
      $error("more than one slave request valid");
    end

  // A slave request needs a mapped address of that very port
  routed_to_port: assert property (@(posedge clk_i) disable iff (rst_i)
    (slv_req_valid_i != '0) |->
      (slv_req_addr_i[AddrWidth-1:PortSelLsb+PortSelBits] == MapTag) &&
      slv_req_valid_i[slv_req_addr_i[PortSelLsb +: PortSelBits]])
    else begin
      fail_cnt++;
      $error("slave request on a port that does not own the address");
    end

  error_data_zero: assert property (@(posedge clk_i) disable iff (rst_i)
    rsp_valid_i && (rsp_resp_i != RESP_OKAY) |-> (rsp_rdata_i == '0))
    else begin
      fail_cnt++;
      $error("error response with nonzero read data");
    end

  rsp_hold: assert property (@(posedge clk_i) disable iff (rst_i)
    rsp_valid_i && !rsp_ready_i |=>
      rsp_valid_i && $stable(rsp_id_i) && $stable(rsp_resp_i) && $stable(rsp_rdata_i))
    else begin
      fail_cnt++;
      $error("host response changed while stalled");
    end

  rsp_no_grant: assert property (@(posedge clk_i) disable iff (rst_i)
    rsp_valid_i && !rsp_ready_i |-> (slv_rsp_ready_i == '0))
    else begin
      fail_cnt++;
      $error("slave response taken while host stalls");
    end

  for (genvar p = 0; p < NumPorts; p++) begin : gen_port_checks
    isolated_drained: assert property (@(posedge clk_i) disable iff (rst_i)
      slv_isolated_i[p] |-> (pend_cnt[p] == '0))
      else begin
        fail_cnt++;
        $error("port %0d isolated with responses outstanding", p);
      end

    // Once isolate is seen with the bus idle, nothing new goes out
    isolate_blocks: assert property (@(posedge clk_i) disable iff (rst_i)
      slv_isolate_i[p] && !slv_req_valid_i[p] |=>
        !slv_req_valid_i[p] || !slv_isolate_i[p])
      else begin
        fail_cnt++;
        $error("port %0d got a new request while isolating", p);
      end
  end

endmodule

bind ext_port_bridge ext_port_bridge_assertions u_assertions (
  .clk_i           ( clk_i           ),
  .rst_i           ( rst_i           ),
  .rsp_valid_i     ( rsp_valid_o     ),
  .rsp_id_i        ( rsp_id_o        ),
  .rsp_resp_i      ( rsp_resp_o      ),
  .rsp_rdata_i     ( rsp_rdata_o     ),
  .rsp_ready_i     ( rsp_ready_i     ),
  .slv_req_valid_i ( slv_req_valid_o ),
  .slv_req_ready_i ( slv_req_ready_i ),
  .slv_req_addr_i  ( slv_req_addr_o  ),
  .slv_rsp_valid_i ( slv_rsp_valid_i ),
  .slv_rsp_ready_i ( slv_rsp_ready_o ),
  .slv_isolate_i   ( slv_isolate_i   ),
  .slv_isolated_i  ( slv_isolated_o  )
);

/* ext_port_bridge_tb.sv */
// --------------------------------------------------
// Testbench of the external slave bridge: host driver,
// four slave models, response scoreboard by ID
// --------------------------------------------------

`timescale 1ns/1ns

module ext_port_bridge_tb;
  import bridge_map_pkg::*;
  import bridge_txn_pkg::*;

  logic                               clk_i;
  logic                               rst_i;
  logic                               req_valid_i;
  op_e                                req_op_i;
  logic [IdWidth-1:0]                 req_id_i;
  logic [AddrWidth-1:0]               req_addr_i;
  logic [DataWidth-1:0]               req_wdata_i;
  logic                               req_ready_o;
  logic                               rsp_valid_o;
  logic [IdWidth-1:0]                 rsp_id_o;
  resp_e                              rsp_resp_o;
  logic [DataWidth-1:0]               rsp_rdata_o;
  logic                               rsp_ready_i;
  logic [NumPorts-1:0]                slv_req_valid_o;
  op_e                                slv_req_op_o;
  logic [IdWidth-1:0]                 slv_req_id_o;
  logic [AddrWidth-1:0]               slv_req_addr_o;
  logic [DataWidth-1:0]               slv_req_wdata_o;
  logic [NumPorts-1:0]                slv_req_ready_i;
  logic [NumPorts-1:0]                slv_rsp_valid_i;
  logic [NumPorts-1:0][IdWidth-1:0]   slv_rsp_id_i;
  resp_e [NumPorts-1:0]               slv_rsp_resp_i;
  logic [NumPorts-1:0][DataWidth-1:0] slv_rsp_rdata_i;
  logic [NumPorts-1:0]                slv_rsp_ready_o;
  logic [NumPorts-1:0]                slv_isolate_i;
  logic [NumPorts-1:0]                slv_isolated_o;

  // One scoreboard entry per ID
  logic [15:0]          exp_busy;
  resp_e                exp_resp [16];
  logic [DataWidth-1:0] exp_data [16];
  logic [DataWidth-1:0] model_mem [logic [AddrWidth-1:0]];

  // Slave model state
  logic [DataWidth-1:0] mem [NumPorts][16];
  bit                   mem_ok [NumPorts][16];
  logic [IdWidth-1:0]   rq_id [NumPorts][8];
  logic [DataWidth-1:0] rq_data [NumPorts][8];
  int                   rq_rd [NumPorts];
  int                   rq_wr [NumPorts];
  int                   stall [NumPorts];

  // Bus snapshot taken at the falling edge
  logic [NumPorts-1:0]  req_fire;
  logic [NumPorts-1:0]  rsp_fire;
  op_e                  s_op;
  logic [IdWidth-1:0]   s_id;
  logic [AddrWidth-1:0] s_addr;
  logic [DataWidth-1:0] s_wdata;
  int                   s_mode;

  // 0 host always ready, 1 host stalls, 2 random
  int rsp_mode;
  int err_cnt;
  int test_err_base;
  int tests_passed;
  int tests_failed;
  int total_err;

  ext_port_bridge u_dut (.*);

  always #2 clk_i = ~clk_i;

  task automatic give_up(input string what);
    $display("timeout while waiting for %s at time %0t", what, $time);
    $display("STATUS: FAIL");
    $finish;
  endtask

  task automatic idle(input int n);
    repeat (n) begin
      @(posedge clk_i);
      #1;
    end
  endtask

  function automatic logic [AddrWidth-1:0] port_addr(input int p, input int off);
    return 32'h1000_0000 + (32'(p) << PortSelLsb) + 32'(off);
  endfunction

  function automatic logic [IdWidth-1:0] free_id();
    logic [IdWidth-1:0] start;
    logic [IdWidth-1:0] cand;
    start = IdWidth'($urandom);
    for (int k = 0; k < 16; k++) begin
      cand = start + IdWidth'(k);
      if (!exp_busy[cand]) begin
        return cand;
      end
    end
    return start;
  endfunction

  // Drive one request and record the answer the address map calls for
  task automatic issue(input op_e op, input logic [AddrWidth-1:0] addr, input resp_e exp);
    logic [IdWidth-1:0]   id;
    logic [DataWidth-1:0] wdata;
    logic [DataWidth-1:0] edata;
    int                   cyc;
    id    = free_id();
    wdata = $urandom;
    edata = '0;
    if (exp == RESP_OKAY && op == OP_READ) begin
      edata = model_mem.exists(addr) ? model_mem[addr] : addr ^ 32'hA5A5_A5A5;
    end
    if (exp == RESP_OKAY && op == OP_WRITE) begin
      model_mem[addr] = wdata;
    end
    exp_busy[id] = 1'b1;
    exp_resp[id] = exp;
    exp_data[id] = edata;
    req_valid_i  = 1'b1;
    req_op_i     = op;
    req_id_i     = id;
    req_addr_i   = addr;
    req_wdata_i  = wdata;
    cyc = 0;
    do begin
      @(negedge clk_i);
      cyc++;
      if (cyc > 200) begin
        give_up("the request handshake");
      end
    end while (!req_ready_o);
    @(posedge clk_i);
    #1;
    req_valid_i = 1'b0;
  endtask

  task automatic wait_idle();
    int cyc;
    cyc = 0;
    while (exp_busy != '0) begin
      @(posedge clk_i);
      #1;
      cyc++;
      if (cyc > 1000) begin
        give_up("all outstanding responses");
      end
    end
  endtask

  task automatic wait_isolated(input int p, input logic level);
    int cyc;
    cyc = 0;
    while (slv_isolated_o[p] != level) begin
      @(posedge clk_i);
      #1;
      cyc++;
      if (cyc > 200) begin
        give_up("the isolation state to change");
      end
    end
  endtask

  task automatic check_rsp(input logic [IdWidth-1:0] id, input resp_e resp,
                           input logic [DataWidth-1:0] rdata);
    if (!exp_busy[id]) begin
      $display("unexpected response for ID %0d at time %0t", id, $time);
      err_cnt++;
    end else begin
      if (resp != exp_resp[id]) begin
        $display("FAIL time %0t rsp_resp_o expected %0d actual %0d",
                 $time, exp_resp[id], resp);
        err_cnt++;
      end
      if (rdata != exp_data[id]) begin
        $display("FAIL time %0t rsp_rdata_o expected %h actual %h",
                 $time, exp_data[id], rdata);
        err_cnt++;
      end
      exp_busy[id] = 1'b0;
    end
  endtask

  // In-order slave with a random accept stall
  task automatic serve_port(input int p);
    logic [3:0]           widx;
    logic [DataWidth-1:0] rdat;
    if (rsp_fire[p]) begin
      rq_rd[p]++;
    end
    if (req_fire[p]) begin
      widx = s_addr[5:2];
      rdat = '0;
      if (s_op == OP_WRITE) begin
        mem[p][widx]    = s_wdata;
        mem_ok[p][widx] = 1'b1;
      end else if (mem_ok[p][widx]) begin
        rdat = mem[p][widx];
      end else begin
        rdat = s_addr ^ 32'hA5A5_A5A5;
      end
      rq_id[p][rq_wr[p] % 8]   = s_id;
      rq_data[p][rq_wr[p] % 8] = rdat;
      rq_wr[p]++;
      stall[p] = $urandom % 3;
    end else if (stall[p] != 0) begin
      stall[p]--;
    end
    slv_req_ready_i[p] = (stall[p] == 0);
    slv_rsp_valid_i[p] = (rq_wr[p] != rq_rd[p]);
    slv_rsp_id_i[p]    = rq_id[p][rq_rd[p] % 8];
    slv_rsp_rdata_i[p] = rq_data[p][rq_rd[p] % 8];
  endtask

  task automatic end_test(input string name);
    int now_err;
    now_err = err_cnt + u_dut.u_assertions.fail_cnt;
    if (now_err == test_err_base) begin
      tests_passed++;
      $display("test %s: passed", name);
    end else begin
      tests_failed++;
      $display("test %s: failed with %0d errors", name, now_err - test_err_base);
    end
    test_err_base = now_err;
  endtask

  // Sample at the falling edge, drive 1 ns after the rising edge
  always begin
    @(negedge clk_i);
    req_fire = slv_req_valid_o & slv_req_ready_i;
    rsp_fire = slv_rsp_valid_i & slv_rsp_ready_o;
    s_op     = slv_req_op_o;
    s_id     = slv_req_id_o;
    s_addr   = slv_req_addr_o;
    s_wdata  = slv_req_wdata_o;
    s_mode   = rsp_mode;
    if (rsp_valid_o && rsp_ready_i) begin
      check_rsp(rsp_id_o, rsp_resp_o, rsp_rdata_o);
    end
    @(posedge clk_i);
    #1;
    for (int p = 0; p < NumPorts; p++) begin
      serve_port(p);
    end
    if (s_mode == 0) begin
      rsp_ready_i = 1'b1;
    end else if (s_mode == 1) begin
      rsp_ready_i = 1'b0;
    end else begin
      rsp_ready_i = 1'($urandom);
    end
  end

  initial begin
    void'($urandom(89));
    clk_i           = 1'b0;
    rst_i           = 1'b1;
    req_valid_i     = 1'b0;
    req_op_i        = OP_READ;
    req_id_i        = '0;
    req_addr_i      = '0;
    req_wdata_i     = '0;
    rsp_ready_i     = 1'b1;
    slv_req_ready_i = '0;
    slv_rsp_valid_i = '0;
    slv_rsp_id_i    = '0;
    slv_rsp_rdata_i = '0;
    slv_isolate_i   = '0;
    for (int p = 0; p < NumPorts; p++) begin
      slv_rsp_resp_i[p] = RESP_OKAY;
    end
    exp_busy      = '0;
    rsp_mode      = 0;
    err_cnt       = 0;
    test_err_base = 0;
    tests_passed  = 0;
    tests_failed  = 0;
    repeat (4) @(posedge clk_i);
    #1;
    rst_i = 1'b0;
    idle(2);
    end_test("reset_values");

    for (int p = 0; p < NumPorts; p++) begin
      issue(OP_WRITE, port_addr(p, 8), RESP_OKAY);
      issue(OP_READ, port_addr(p, 8), RESP_OKAY);
      issue(OP_READ, port_addr(p, 32), RESP_OKAY);
    end
    wait_idle();
    end_test("write_read_ports");

    issue(OP_WRITE, 32'h2000_0000, RESP_DECERR);
    issue(OP_READ, 32'h1000_4010, RESP_DECERR);
    wait_idle();
    end_test("decode_error");

    // Hold the host so responses pile up behind port 1
    rsp_mode = 1;
    issue(OP_WRITE, port_addr(1, 0), RESP_OKAY);
    issue(OP_WRITE, port_addr(1, 4), RESP_OKAY);
    issue(OP_READ, port_addr(1, 0), RESP_OKAY);
    slv_isolate_i[1] = 1'b1;
    idle(4);
    rsp_mode = 0;
    // Request during the drain stalls, then ends locally
    issue(OP_WRITE, port_addr(1, 8), RESP_SLVERR);
    wait_isolated(1, 1'b1);
    wait_idle();
    end_test("isolate_drain");

    issue(OP_WRITE, port_addr(1, 0), RESP_SLVERR);
    issue(OP_READ, port_addr(1, 4), RESP_SLVERR);
    wait_idle();
    slv_isolate_i[1] = 1'b0;
    wait_isolated(1, 1'b0);
    issue(OP_READ, port_addr(1, 0), RESP_OKAY);
    issue(OP_WRITE, port_addr(1, 12), RESP_OKAY);
    issue(OP_READ, port_addr(1, 12), RESP_OKAY);
    wait_idle();
    end_test("isolated_slverr");

    rsp_mode = 2;
    repeat (12) begin
      issue(($urandom % 2) ? OP_WRITE : OP_READ,
            port_addr($urandom % NumPorts, ($urandom % 4) * 4), RESP_OKAY);
    end
    wait_idle();
    rsp_mode = 0;
    end_test("backpressure_mix");

    total_err = err_cnt + u_dut.u_assertions.fail_cnt;
    $display("tests passed %0d failed %0d, errors %0d", tests_passed, tests_failed, total_err);
    if (tests_failed == 0 && total_err == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

/* ext_port_isolate.sv */
// --------------------------------------------------
// Isolation stage of one external slave port: counts
// pending requests, drains on isolate and answers
// requests locally with SLVERR once isolated
// --------------------------------------------------

`timescale 1ns/1ns

module ext_port_isolate
  import bridge_map_pkg::*;
  import bridge_txn_pkg::*;
(
  input  logic                 clk_i,
  input  logic                 rst_i,
  // From the router
  input  logic                 in_req_valid_i,
  input  op_e                  in_req_op_i,
  input  logic [IdWidth-1:0]   in_req_id_i,
  output logic                 in_req_ready_o,
  // Toward the external slave
  output logic                 slv_req_valid_o,
  input  logic                 slv_req_ready_i,
  // From the external slave
  input  logic                 slv_rsp_valid_i,
  input  logic [IdWidth-1:0]   slv_rsp_id_i,
  input  resp_e                slv_rsp_resp_i,
  input  logic [DataWidth-1:0] slv_rsp_rdata_i,
  output logic                 slv_rsp_ready_o,
  // Toward the arbiter
  output logic                 out_rsp_valid_o,
  output logic [IdWidth-1:0]   out_rsp_id_o,
  output resp_e                out_rsp_resp_o,
  output logic [DataWidth-1:0] out_rsp_rdata_o,
  input  logic                 out_rsp_ready_i,
  // Isolation control
  input  logic                 isolate_i,
  output logic                 isolated_o
);

  iso_state_e              state_q, state_d;
  logic [PendCntWidth-1:0] pend_q;
  logic                    has_room;
  logic                    req_fire;
  logic                    rsp_fire;
  logic                    term_accept;
  logic                    term_valid_q;
  logic [IdWidth-1:0]      term_id_q;

  assign has_room = (pend_q != PendCntWidth'(MaxPending));
  assign req_fire = slv_req_valid_o && slv_req_ready_i;
  assign rsp_fire = slv_rsp_valid_i && slv_rsp_ready_o;

  always_comb begin
    slv_req_valid_o = 1'b0;
    in_req_ready_o  = 1'b0;
    term_accept     = 1'b0;
    unique case (state_q)
      ISO_RUN: begin
        slv_req_valid_o = in_req_valid_i && has_room;
        in_req_ready_o  = slv_req_ready_i && has_room;
      end
      ISO_ISOLATED: begin
        in_req_ready_o = !term_valid_q;
        term_accept    = in_req_valid_i && !term_valid_q;
      end
      default: begin
        // Drain stalls every new request
        in_req_ready_o = 1'b0;
      end
    endcase
  end

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      ISO_RUN: begin
        // Let a stalled request finish its handshake first
        if (isolate_i && !(slv_req_valid_o && !slv_req_ready_i)) begin
          state_d = ISO_DRAIN;
        end
      end
      ISO_DRAIN: begin
        if (!isolate_i) begin
          state_d = ISO_RUN;
        end else if (pend_q == '0) begin
          state_d = ISO_ISOLATED;
        end
      end
      ISO_ISOLATED: begin
        if (!isolate_i) begin
          state_d = ISO_RUN;
        end
      end
      default: state_d = ISO_RUN;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q      <= ISO_RUN;
      pend_q       <= '0;
      term_valid_q <= 1'b0;
    end else begin
      state_q <= state_d;
      if (req_fire && !rsp_fire) begin
        pend_q <= pend_q + PendCntWidth'(1);
      end else if (!req_fire && rsp_fire) begin
        pend_q <= pend_q - PendCntWidth'(1);
      end
      if (term_accept) begin
        term_valid_q <= 1'b1;
      end else if (out_rsp_ready_i) begin
        term_valid_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (term_accept) begin
      term_id_q <= in_req_id_i;
    end
  end

  // Terminated answer goes first, the slave waits behind it
  assign out_rsp_valid_o = term_valid_q || slv_rsp_valid_i;
  assign out_rsp_id_o    = term_valid_q ? term_id_q : slv_rsp_id_i;
  assign out_rsp_resp_o  = term_valid_q ? RESP_SLVERR : slv_rsp_resp_i;
  assign out_rsp_rdata_o = term_valid_q ? '0 : slv_rsp_rdata_i;
  assign slv_rsp_ready_o = out_rsp_ready_i && !term_valid_q;

  assign isolated_o = (state_q == ISO_ISOLATED);

endmodule

/* ext_port_router.sv */
// --------------------------------------------------
// Request router: decodes the address to one of the
// external ports, answers unmapped accesses with a
// decode error through a one-entry register
// --------------------------------------------------

`timescale 1ns/1ns

module ext_port_router
  import bridge_map_pkg::*;
  import bridge_txn_pkg::*;
(
  input  logic                 clk_i,
  input  logic                 rst_i,
  // Host request
  input  logic                 req_valid_i,
  input  op_e                  req_op_i,
  input  logic [IdWidth-1:0]   req_id_i,
  input  logic [AddrWidth-1:0] req_addr_i,
  input  logic [DataWidth-1:0] req_wdata_i,
  output logic                 req_ready_o,
  // Toward the isolation stages
  output logic [NumPorts-1:0]  port_req_valid_o,
  input  logic [NumPorts-1:0]  port_req_ready_i,
  // Decode error toward the arbiter
  output logic                 dec_rsp_valid_o,
  output logic [IdWidth-1:0]   dec_rsp_id_o,
  input  logic                 dec_rsp_ready_i
);

  logic                   tag_hit;
  logic [PortSelBits-1:0] port_sel;
  logic                   dec_accept;

  assign tag_hit  = (req_addr_i[AddrWidth-1:PortSelLsb+PortSelBits] == MapTag);
  assign port_sel = req_addr_i[PortSelLsb +: PortSelBits];

  // One-hot valid, only the addressed port sees the request
  always_comb begin
    port_req_valid_o           = '0;
    port_req_valid_o[port_sel] = req_valid_i && tag_hit;
  end

  assign req_ready_o = tag_hit ? port_req_ready_i[port_sel] : !dec_rsp_valid_o;
  assign dec_accept  = req_valid_i && !tag_hit && !dec_rsp_valid_o;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      dec_rsp_valid_o <= 1'b0;
    end else if (dec_accept) begin
      dec_rsp_valid_o <= 1'b1;
    end else if (dec_rsp_ready_i) begin
      dec_rsp_valid_o <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (dec_accept) begin
      dec_rsp_id_o <= req_id_i;
    end
  end

endmodule

/* ext_rsp_arbiter.sv */
// --------------------------------------------------
// Response arbiter: round-robin over the port
// responses and the decode error, one output register
// --------------------------------------------------

`timescale 1ns/1ns

module ext_rsp_arbiter
  import bridge_map_pkg::*;
  import bridge_txn_pkg::*;
(
  input  logic                               clk_i,
  input  logic                               rst_i,
  // From the isolation stages
  input  logic [NumPorts-1:0]                port_rsp_valid_i,
  input  logic [NumPorts-1:0][IdWidth-1:0]   port_rsp_id_i,
  input  resp_e [NumPorts-1:0]               port_rsp_resp_i,
  input  logic [NumPorts-1:0][DataWidth-1:0] port_rsp_rdata_i,
  output logic [NumPorts-1:0]                port_rsp_ready_o,
  // Decode error from the router
  input  logic                               dec_rsp_valid_i,
  input  logic [IdWidth-1:0]                 dec_rsp_id_i,
  output logic                               dec_rsp_ready_o,
  // Toward the host
  output logic                               rsp_valid_o,
  output logic [IdWidth-1:0]                 rsp_id_o,
  output resp_e                              rsp_resp_o,
  output logic [DataWidth-1:0]               rsp_rdata_o,
  input  logic                               rsp_ready_i
);

  // Source NumPorts is the decode error
  logic [NumPorts:0]                src_valid;
  logic [NumPorts:0][IdWidth-1:0]   src_id;
  logic [NumPorts:0][1:0]           src_resp;
  logic [NumPorts:0][DataWidth-1:0] src_rdata;

  logic [$clog2(NumPorts+1)-1:0] ptr_q;
  logic [$clog2(NumPorts+1)-1:0] gnt_idx;
  logic                          gnt_valid;
  logic                          load_en;

  assign src_valid = {dec_rsp_valid_i, port_rsp_valid_i};
  assign src_id    = {dec_rsp_id_i, port_rsp_id_i};
  assign src_resp  = {RESP_DECERR, port_rsp_resp_i};
  assign src_rdata = {{DataWidth{1'b0}}, port_rsp_rdata_i};

  // Output register empty or draining this cycle
  assign load_en = !rsp_valid_o || rsp_ready_i;

  always_comb begin
    int unsigned idx;
    gnt_valid = 1'b0;
    gnt_idx   = ptr_q;
    for (int unsigned k = 0; k <= NumPorts; k++) begin
      idx = (ptr_q + k) % (NumPorts + 1);
      if (load_en && !gnt_valid && src_valid[idx]) begin
        gnt_valid = 1'b1;
        gnt_idx   = idx[$clog2(NumPorts+1)-1:0];
      end
    end
  end

  always_comb begin
    port_rsp_ready_o = '0;
    for (int unsigned p = 0; p < NumPorts; p++) begin
      port_rsp_ready_o[p] = gnt_valid && (gnt_idx == p);
    end
  end

  assign dec_rsp_ready_o = gnt_valid && (gnt_idx == NumPorts);

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      rsp_valid_o <= 1'b0;
      ptr_q       <= '0;
    end else begin
      if (load_en) begin
        rsp_valid_o <= gnt_valid;
      end
      // Winner drops to lowest priority
      if (gnt_valid) begin
        ptr_q <= (gnt_idx == NumPorts) ? '0 : gnt_idx + 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (gnt_valid) begin
      rsp_id_o    <= src_id[gnt_idx];
      rsp_resp_o  <= resp_e'(src_resp[gnt_idx]);
      rsp_rdata_o <= src_rdata[gnt_idx];
    end
  end

endmodule

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the bridge testbench with Verilator, result taken from sim.log

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal \
  --top-module ext_port_bridge_tb -f ext_port_bridge.f -o ext_port_bridge_sim \
  || { echo "build failed"; exit 1; }

./obj_dir/ext_port_bridge_sim +verilator+error+limit+1000 > sim.log 2>&1
cat sim.log

grep -qx "STATUS: PASS" sim.log && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }
